// ==== files.f ====
hdl/eeprom_pkg.sv
hdl/scl_timer.sv
hdl/byte_shifter.sv
hdl/eeprom_fsm.sv
hdl/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

// ==== verif/tb_eeprom_ctrl.sv ====
`timescale 1ns/100ps

module tb_eeprom_ctrl
    import eeprom_pkg::*;
;

    localparam int CLK_DIV   = 4;
    localparam int RESET_CYC = 8;
    localparam int N_OPS     = 24;
    // a read alone takes close to 80 CLK_DIV cycles, four times 60 per op is ample
    localparam int LIMIT     = 60 * CLK_DIV * N_OPS * 4 + RESET_CYC;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] rd_data;
    logic              ack;
    logic              busy;
    logic              nack_err;
    logic              scl;
    logic              mute;
    wire               sda;

    logic [7:0] sb [0:2047];   // expected memory contents
    int         err_cnt = 0;
    int         test_cnt = 0;
    int         test_fail = 0;
    int         err_mark = 0;
    int         cyc = 0;
    int         starts = 0;
    int         stops = 0;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       busy_q = 1'b0;
    logic       pending = 1'b0;
    logic       op_started = 1'b0;

    pullup (sda);

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) i_eeprom_ctrl_top (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .ack      (ack),
        .busy     (busy),
        .nack_err (nack_err),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model i_eeprom_model (.scl(scl), .sda(sda), .mute(mute));

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // bus condition counters, cleared when an operation begins
    always @(posedge CLK)
    begin
        scl_q  <= scl;
        sda_q  <= (sda !== 1'b0);
        busy_q <= busy;
        if (busy && !busy_q)
        begin
            starts  <= 0;
            stops   <= 0;
            pending <= 1'b1;
        end
        else
        begin
            if (scl && scl_q && sda_q && sda === 1'b0)
                starts <= starts + 1;
            if (scl && scl_q && !sda_q && sda !== 1'b0)
                stops <= stops + 1;
            if (ack)
                pending <= 1'b0;
        end
    end

    always @(posedge CLK)
    begin
        cyc <= cyc + 1;
        if (cyc > LIMIT)
        begin
            $display("timeout: no ack after %0d cycles", cyc);
            $display("Simulation FAILED");
            $finish;
        end
    end

    a_reset_idle: assert property (@(posedge CLK) disable iff (RESET)
        !op_started |-> (scl && sda === 1'b1 && !ack && !busy && !nack_err))
        else
        begin
            err_cnt++;
            $display("bus or outputs not idle after reset");
        end

    // a level change with scl high is a start or stop, made only during an operation
    a_bus_rule: assert property (@(posedge CLK) disable iff (RESET)
        (scl && scl_q && ((sda !== 1'b0) != sda_q)) |-> busy)
        else
        begin
            err_cnt++;
            $display("sda changed with scl high outside an operation");
        end

    a_ack_once: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> pending)
        else
        begin
            err_cnt++;
            $display("ack pulse without an accepted operation");
        end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            err_cnt++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic run_op(input bit is_wr, input logic [10:0] a, input logic [7:0] d,
                          output logic [7:0] got, output logic nerr);
        @(posedge CLK);
        wr         <= is_wr;
        rd         <= !is_wr;
        addr       <= a;
        wr_data    <= d;
        op_started <= 1'b1;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        do
            @(negedge CLK);
        while (!ack);
        got  = rd_data;
        nerr = nack_err;
        @(negedge CLK);  // stop rises in the ack cycle, counted on the next edge
        if (!nerr)
            check_val("starts", starts, is_wr ? 1 : 2);
        check_val("stops", stops, 1);
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
        logic [7:0] got;
        logic       nerr;
        run_op(1'b1, a, d, got, nerr);
        check_val("nack_err", nerr, 0);
        if (!nerr)
            sb[a] = d;
    endtask

    task automatic read_check(input logic [10:0] a);
        logic [7:0] got;
        logic       nerr;
        run_op(1'b0, a, 8'h00, got, nerr);
        check_val("nack_err", nerr, 0);
        check_val("rd_data", got, sb[a]);
    endtask

    task automatic close_test(input string name);
        test_cnt++;
        if (err_cnt > err_mark)
        begin
            test_fail++;
            $display("test %0d %s: fail, %0d errors", test_cnt, name, err_cnt - err_mark);
        end
        else
            $display("test %0d %s: ok", test_cnt, name);
        err_mark = err_cnt;
    endtask

    initial
    begin
        logic [10:0] a0;
        logic [10:0] a1;
        logic [10:0] a2;
        logic [7:0]  low;
        logic [7:0]  got;
        logic        nerr;

        void'($urandom(32'h09008dc8));
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        mute    = 1'b0;
        for (int i = 0; i < 2048; i++)
        begin
            sb[i]                  = i[7:0] ^ {i[10:8], 5'h15};
            i_eeprom_model.mem[i] = sb[i];
        end
        repeat (RESET_CYC) @(posedge CLK);
        RESET <= 1'b0;

        repeat (20) @(posedge CLK);
        close_test("reset state");

        a0 = 11'($urandom);
        write_byte(a0, 8'($urandom));
        read_check(a0);
        close_test("write then read");

        low = 8'($urandom);
        for (int b = 0; b < 8; b++)
            write_byte({3'(b), low}, 8'($urandom));
        for (int b = 0; b < 8; b++)
            read_check({3'(b), low});
        close_test("block bits");

        @(posedge CLK);
        mute <= 1'b1;
        run_op(1'b1, a0, ~sb[a0], got, nerr);
        check_val("nack_err", nerr, 1);
        @(posedge CLK);
        mute <= 1'b0;
        read_check(a0);
        close_test("missing acknowledge");

        a1 = {3'd5, 8'($urandom)};
        a2 = a1 ^ 11'h0c3;
        fork
            write_byte(a1, 8'($urandom));
            begin
                do
                    @(negedge CLK);
                while (!busy);
                @(posedge CLK);
                wr      <= 1'b1;   // must be ignored
                addr    <= a2;
                wr_data <= ~sb[a2];
                repeat (3) @(posedge CLK);
                wr <= 1'b0;
            end
        join
        read_check(a2);
        read_check(a1);
        close_test("request while busy");

        repeat (10) @(posedge CLK);
        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verif/eeprom_model.sv ====
`timescale 1ns/100ps

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic mute   // withhold every acknowledge
);

    localparam int P_IDLE  = 0;
    localparam int P_CTRL  = 1;
    localparam int P_ADDR  = 2;
    localparam int P_WDATA = 3;
    localparam int P_RDATA = 4;

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  rbyte;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic        rw;
    logic        sda_low = 1'b0;
    int          phase   = P_IDLE;
    int          bit_cnt = 0;

    assign sda = sda_low ? 1'b0 : 1'bz;

    // start and stop conditions
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase   = P_CTRL;
            bit_cnt = 0;
            sda_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase   = P_IDLE;
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE && bit_cnt < 8)
        begin
            shreg   = {shreg[6:0], sda !== 1'b0};
            bit_cnt = bit_cnt + 1;
        end
    end

    // line changes only while scl is low
    always @(negedge scl)
    begin
        if (phase != P_IDLE)
        begin
            if (bit_cnt == 8)
            begin
                bit_cnt = 9;    // ack slot
                if (phase == P_RDATA)
                    sda_low = 1'b0;
                else if (mute || (phase == P_CTRL && shreg[7:4] != DEV_CODE))
                    phase = P_IDLE;
                else
                begin
                    case (phase)
                        P_CTRL:
                        begin
                            blk = shreg[3:1];
                            rw  = shreg[0];
                        end
                        P_ADDR:  ptr = {blk, shreg};
                        P_WDATA: mem[ptr] = shreg;
                        default: ;
                    endcase
                    sda_low = 1'b1;
                end
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt = 0;
                sda_low = 1'b0;
                case (phase)
                    P_CTRL:  phase = rw ? P_RDATA : P_ADDR;
                    P_ADDR:  phase = P_WDATA;
                    P_RDATA: phase = P_IDLE;
                    default: ;
                endcase
                if (phase == P_RDATA)
                begin
                    rbyte   = mem[ptr];
                    sda_low = !rbyte[7];
                end
            end
            else if (phase == P_RDATA)
                sda_low = !rbyte[7 - bit_cnt];
        end
    end

endmodule

// ==== hdl/eeprom_ctrl_top.sv ====
`timescale 1ns/100ps

module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wr_data,
    output logic [DATA_W-1:0] rd_data,
    output logic              ack,
    output logic              busy,
    output logic              nack_err,
    output logic              scl,
    inout  wire               sda
);

    logic              run;
    logic              low_mid;
    logic              high_mid;
    logic              load;
    logic [DATA_W-1:0] tx_byte;
    logic              read_mode;
    logic              sda_bit;
    logic [DATA_W-1:0] rx_byte;
    logic              ack_bit;
    logic              done;

    scl_timer #(
        .CLK_DIV  (CLK_DIV)
    ) i_scl_timer (
        .CLK      (CLK),
        .RESET    (RESET),
        .run      (run),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    byte_shifter i_byte_shifter (
        .CLK       (CLK),
        .RESET     (RESET),
        .load      (load),
        .tx_byte   (tx_byte),
        .read_mode (read_mode),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .sda_in    (sda),       // pin level, slave included
        .sda_bit   (sda_bit),
        .rx_byte   (rx_byte),
        .ack_bit   (ack_bit),
        .done      (done)
    );

    eeprom_fsm i_eeprom_fsm (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .sda_bit   (sda_bit),
        .rx_byte   (rx_byte),
        .ack_bit   (ack_bit),
        .done      (done),
        .run       (run),
        .load      (load),
        .tx_byte   (tx_byte),
        .read_mode (read_mode),
        .sda       (sda),
        .rd_data   (rd_data),
        .ack       (ack),
        .busy      (busy),
        .nack_err  (nack_err)
    );

endmodule

// ==== hdl/eeprom_fsm.sv ====
`timescale 1ns/100ps

module eeprom_fsm
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              low_mid,
    input  logic              high_mid,
    input  logic              sda_bit,
    input  logic [DATA_W-1:0] rx_byte,
    input  logic              ack_bit,
    input  logic              done,
    output logic              run,
    output logic              load,
    output logic [DATA_W-1:0] tx_byte,
    output logic              read_mode,
    inout  wire               sda,
    output logic [DATA_W-1:0] rd_data,
    output logic              ack,
    output logic              busy,
    output logic              nack_err
);

    main_state_t state;

    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic              is_rd;
    logic              own_lvl;   // start/stop level driven by the sequencer
    logic              drive_sh;  // shifter owns the line
    logic              low_seen;
    logic              accept;
    logic              byte_st;
    logic              nack_hit;
    logic              sda_lvl;

    assign accept   = (state == ST_IDLE) && (wr || rd);
    assign byte_st  = state inside {ST_CTRL_W, ST_ADDR, ST_DATA_W, ST_CTRL_R, ST_DATA_R};
    assign nack_hit = done && ack_bit && (state != ST_DATA_R);  // master nacks data_r itself

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            run      <= 1'b0;
            load     <= 1'b0;
            own_lvl  <= 1'b1;
            drive_sh <= 1'b0;
            low_seen <= 1'b0;
            is_rd    <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            load     <= 1'b0;
            // hand the line to the shifter at its first bit
            drive_sh <= byte_st && (drive_sh || low_mid);

            case (state)
                ST_IDLE:
                    if (accept)
                    begin
                        is_rd    <= !wr;  // write wins
                        nack_err <= 1'b0;
                        run      <= 1'b1;
                        state    <= ST_START;
                    end
                ST_START:
                    if (high_mid)
                    begin
                        own_lvl <= 1'b0;  // sda falls, scl high
                        load    <= 1'b1;
                        state   <= ST_CTRL_W;
                    end
                ST_CTRL_W, ST_ADDR, ST_DATA_W, ST_CTRL_R, ST_DATA_R:
                    if (done)
                    begin
                        own_lvl  <= 1'b1;
                        low_seen <= 1'b0;
                        if (nack_hit)
                        begin
                            nack_err <= 1'b1;
                            state    <= ST_STOP;
                        end
                        else if (state == ST_CTRL_W)
                        begin
                            load  <= 1'b1;
                            state <= ST_ADDR;
                        end
                        else if (state == ST_ADDR && is_rd)
                            state <= ST_RESTART;
                        else if (state == ST_ADDR)
                        begin
                            load  <= 1'b1;
                            state <= ST_DATA_W;
                        end
                        else if (state == ST_CTRL_R)
                        begin
                            load  <= 1'b1;
                            state <= ST_DATA_R;
                        end
                        else
                            state <= ST_STOP;
                    end
                ST_RESTART:
                    if (low_mid)
                    begin
                        own_lvl  <= 1'b1;
                        low_seen <= 1'b1;
                    end
                    else if (high_mid && low_seen)
                    begin
                        own_lvl <= 1'b0;  // repeated start
                        load    <= 1'b1;
                        state   <= ST_CTRL_R;
                    end
                ST_STOP:
                    if (low_mid)
                    begin
                        own_lvl  <= 1'b0;
                        low_seen <= 1'b1;
                    end
                    else if (high_mid && low_seen)
                    begin
                        own_lvl <= 1'b1;  // sda rises, scl high
                        run     <= 1'b0;
                        state   <= ST_DONE;
                    end
                ST_DONE:
                    state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == ST_DATA_R && done)
            rd_data <= rx_byte;
    end

    always_comb
    begin
        case (state)
            ST_CTRL_W: tx_byte = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b0};
            ST_ADDR:   tx_byte = addr_q[DATA_W-1:0];
            ST_DATA_W: tx_byte = data_q;
            ST_CTRL_R: tx_byte = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b1};
            default:   tx_byte = '1;
        endcase
    end

    assign read_mode = (state == ST_DATA_R);
    assign ack       = (state == ST_DONE);
    assign busy      = (state != ST_IDLE);

    // open drain pin
    assign sda_lvl = drive_sh ? sda_bit : own_lvl;
    assign sda     = sda_lvl ? 1'bz : 1'b0;

    a_single_ack: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    a_load_in_byte: assert property (@(posedge CLK) disable iff (RESET)
        load |-> byte_st);

endmodule

// ==== hdl/byte_shifter.sv ====
`timescale 1ns/100ps

module byte_shifter
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              load,
    input  logic [DATA_W-1:0] tx_byte,
    input  logic              read_mode,
    input  logic              low_mid,
    input  logic              high_mid,
    input  logic              sda_in,
    output logic              sda_bit,
    output logic [DATA_W-1:0] rx_byte,
    output logic              ack_bit,
    output logic              done
);

    localparam int SW = $clog2(LAST_SLOT + 1);
    localparam logic [SW-1:0] SLOT_END = SW'(LAST_SLOT);

    logic [DATA_W-1:0] tx_reg;
    logic [DATA_W-1:0] rx_reg;
    logic [SW-1:0]     slot;
    logic              armed;   // loaded, waiting for the first low_mid
    logic              active;  // bits are moving

    logic [DATA_W-1:0] cur_tx;
    logic [SW-1:0]     cur_slot;

    // load may coincide with the first low_mid when CLK_DIV is small
    assign cur_tx   = load ? tx_byte : tx_reg;
    assign cur_slot = load ? '0 : slot;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            slot    <= '0;
            armed   <= 1'b0;
            active  <= 1'b0;
            sda_bit <= 1'b1;
            ack_bit <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;

            if (low_mid && (load || armed || active))
            begin
                // read data and the ack slot leave the line released
                sda_bit <= (read_mode || cur_slot == SLOT_END) ? 1'b1 : cur_tx[DATA_W-1];
                armed   <= 1'b0;
                active  <= 1'b1;
            end
            else if (load)
            begin
                armed  <= 1'b1;
                active <= 1'b0;
            end

            if (load)
            begin
                slot <= '0;
            end
            else if (high_mid && active)
            begin
                if (slot == SLOT_END)
                begin
                    ack_bit <= sda_in;  // 0 = ack
                    done    <= 1'b1;
                    active  <= 1'b0;
                end
                else
                begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // shift registers, msb first
    always_ff @(posedge CLK)
    begin
        if (load)
            tx_reg <= tx_byte;
        else if (high_mid && active && slot != SLOT_END)
        begin
            tx_reg <= tx_reg << 1;
            rx_reg <= {rx_reg[DATA_W-2:0], sda_in};
        end
    end

    assign rx_byte = rx_reg;

    a_done_in_ack_slot: assert property (@(posedge CLK) disable iff (RESET)
        done |-> (slot == SW'(LAST_SLOT)));

endmodule

// ==== hdl/scl_timer.sv ====
`timescale 1ns/100ps

module scl_timer
#(
    parameter int CLK_DIV = 4
)
(
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CW = $clog2(CLK_DIV);
    localparam logic [CW-1:0] LAST_CNT = CW'(CLK_DIV - 1);
    // strobe on the (CLK_DIV/2)-th cycle of a phase, so its effect lands mid-phase
    localparam logic [CW-1:0] MID_CNT = CW'(CLK_DIV / 2 - 1);

    logic [CW-1:0] cnt;
    logic          active;  // set once the first low phase has begun

    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            scl    <= 1'b1;  // idle bus
            cnt    <= '0;
            active <= 1'b0;
        end
        else if (!active)
        begin
            active <= 1'b1;
            scl    <= 1'b0;
            cnt    <= '0;
        end
        else if (cnt == LAST_CNT)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    assign low_mid  = active && !scl && (cnt == MID_CNT);
    assign high_mid = active && scl && (cnt == MID_CNT);

    a_strobes_apart: assert property (@(posedge CLK) disable iff (RESET)
        !(low_mid && high_mid));

    // a start or stop made at high_mid lands with scl still high
    a_high_mid_scl: assert property (@(posedge CLK) disable iff (RESET)
        high_mid |-> scl ##1 scl);

endmodule

// ==== hdl/eeprom_pkg.sv ====
package eeprom_pkg;

    // control byte prefix for 24Cxx parts
    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam int ADDR_W = 11;  // 2 KB array
    localparam int DATA_W = 8;

    // data slots 0..7, then the acknowledge slot
    localparam int LAST_SLOT = 8;

    // sequencer states
    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,   // control byte, write direction
        ST_ADDR,     // low address byte
        ST_DATA_W,
        ST_RESTART,
        ST_CTRL_R,   // control byte, read direction
        ST_DATA_R,
        ST_STOP,
        ST_DONE
    } main_state_t;

endpackage
